/* Makefile */
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= dcache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Everything OK

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

/* cache_way.sv */
module cache_way
  import dcache_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                we,
  input  logic                fill,
  input  logic                store,
  input  logic [INDEX_W-1:0]  index,
  input  logic [TAG_W-1:0]    tag,
  input  logic [OFFSET_W-1:0] offset,
  input  size_e               size,
  input  logic [DATA_W-1:0]   wdata,
  input  logic [LINE_W-1:0]   refill_line,
  output logic                hit,
  output logic [LINE_W-1:0]   line
);

  localparam int SETS = 2**INDEX_W;

  logic [SETS-1:0]   valid;
  logic [TAG_W-1:0]  tag_mem  [SETS];
  logic [LINE_W-1:0] line_mem [SETS];
  logic [LINE_W-1:0] merged;   // indexed line with the store field replaced

  assign line = line_mem[index];                            // combinational read
  assign hit  = valid[index] && (tag_mem[index] == tag);

  // only the low bytes of wdata are used, as wide as the access
  always_comb begin
    merged = line;
    case (size)
      SIZE_BYTE: begin
        merged[{offset, 3'b000} +: 8] = wdata[7:0];
      end
      SIZE_HALF: begin
        merged[{offset[OFFSET_W-1:1], 4'b0000} +: 16] = wdata[15:0];
      end
      SIZE_WORD: begin
        merged[{offset[OFFSET_W-1:2], 5'b00000} +: 32] = wdata[31:0];
      end
      default: begin
        merged[{offset[OFFSET_W-1], 6'b000000} +: 64] = wdata[63:0];   // double
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
    end else if (we && fill) begin
      valid[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (we && fill) begin
      tag_mem[index]  <= tag;
      line_mem[index] <= refill_line;   // whole line from memory
    end else if (we && store) begin
      line_mem[index] <= merged;
    end
  end

endmodule

/* dcache_pkg.sv */
package dcache_pkg;

  localparam int ADDR_W   = 32;
  localparam int OFFSET_W = 4;   // 16 bytes per line
  localparam int INDEX_W  = 6;   // 64 sets
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int LINE_W   = 128;
  localparam int DATA_W   = 64;

  // code is log2 of the access width in bytes
  typedef enum logic [1:0] {
    SIZE_BYTE   = 2'b00,
    SIZE_HALF   = 2'b01,
    SIZE_WORD   = 2'b10,
    SIZE_DOUBLE = 2'b11
  } size_e;

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } addr_fields_t;

  // raw word for the memory side, fields for the ways
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    addr_fields_t      f;
  } addr_u;

endpackage

/* dcache_top.f */
dcache_pkg.sv
cache_way.sv
miss_ctrl.sv
way_select.sv
dcache_top.sv
tb_dcache.sv

/* dcache_top.sv */
module dcache_top
  import dcache_pkg::*;
#(
  parameter int WAYS = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  size_e             size,
  input  logic              load_unsigned,
  input  logic [DATA_W-1:0] wdata,
  output logic              done,
  output logic [DATA_W-1:0] rdata,
  output logic              mem_req,
  output logic [ADDR_W-1:0] mem_addr,
  input  logic              mem_valid,
  input  logic [LINE_W-1:0] mem_line,
  output logic              mem_we,
  output logic [DATA_W-1:0] mem_wdata,
  output size_e             mem_size
);

  logic                        fill;
  logic                        store;
  logic [WAYS-1:0]             way_we;
  logic [INDEX_W-1:0]          index;
  logic [TAG_W-1:0]            tag;
  logic [OFFSET_W-1:0]         offset;
  size_e                       way_size;
  logic [DATA_W-1:0]           way_wdata;
  logic [LINE_W-1:0]           refill_line;
  logic [WAYS-1:0]             way_hit;
  logic [WAYS-1:0][LINE_W-1:0] way_line;
  logic                        any_hit;
  logic [WAYS-1:0]             hit_way;

  miss_ctrl #(
    .WAYS(WAYS)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .we         (we),
    .addr       (addr),
    .size       (size),
    .wdata      (wdata),
    .any_hit    (any_hit),
    .hit_way    (hit_way),
    .mem_valid  (mem_valid),
    .mem_line   (mem_line),
    .done       (done),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_we     (mem_we),
    .mem_wdata  (mem_wdata),
    .mem_size   (mem_size),
    .fill       (fill),
    .store      (store),
    .way_we     (way_we),
    .index      (index),
    .tag        (tag),
    .offset     (offset),
    .size_out   (way_size),
    .wdata_out  (way_wdata),
    .refill_line(refill_line)
  );

  for (genvar g = 0; g < WAYS; g++) begin : g_way
    cache_way u_way (
      .clk        (clk),
      .rst_n      (rst_n),
      .we         (way_we[g]),
      .fill       (fill),
      .store      (store),
      .index      (index),
      .tag        (tag),
      .offset     (offset),
      .size       (way_size),
      .wdata      (way_wdata),
      .refill_line(refill_line),
      .hit        (way_hit[g]),
      .line       (way_line[g])
    );
  end

  way_select #(
    .WAYS(WAYS)
  ) u_sel (
    .clk          (clk),
    .hit          (way_hit),
    .line         (way_line),
    .offset       (offset),
    .size         (way_size),
    .load_unsigned(load_unsigned),
    .any_hit      (any_hit),
    .hit_way      (hit_way),
    .rdata        (rdata)
  );

endmodule

/* miss_ctrl.sv */
module miss_ctrl
  import dcache_pkg::*;
#(
  parameter int WAYS = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req,
  input  logic                we,
  input  addr_u               addr,
  input  size_e               size,
  input  logic [DATA_W-1:0]   wdata,
  input  logic                any_hit,
  input  logic [WAYS-1:0]     hit_way,
  input  logic                mem_valid,
  input  logic [LINE_W-1:0]   mem_line,
  output logic                done,
  output logic                mem_req,
  output logic [ADDR_W-1:0]   mem_addr,
  output logic                mem_we,
  output logic [DATA_W-1:0]   mem_wdata,
  output size_e               mem_size,
  output logic                fill,
  output logic                store,
  output logic [WAYS-1:0]     way_we,
  output logic [INDEX_W-1:0]  index,
  output logic [TAG_W-1:0]    tag,
  output logic [OFFSET_W-1:0] offset,
  output size_e               size_out,
  output logic [DATA_W-1:0]   wdata_out,
  output logic [LINE_W-1:0]   refill_line
);

  localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;
  localparam int CNT_W = $clog2(WAYS + 1);
  localparam int SETS  = 2**INDEX_W;

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_LOOKUP = 2'd1;
  localparam logic [1:0] ST_REFILL = 2'd2;

  logic [1:0]       state;
  logic [1:0]       state_nxt;
  logic [CNT_W-1:0] fill_cnt [SETS];   // ways filled so far in each set
  logic [WAY_W-1:0] rr_ptr   [SETS];   // next victim once the set is full
  logic [WAY_W-1:0] victim;
  logic             lookup_hit;

  assign index       = addr.f.index;
  assign tag         = addr.f.tag;
  assign offset      = addr.f.offset;
  assign size_out    = size;
  assign wdata_out   = wdata;
  assign refill_line = mem_line;

  assign lookup_hit = (state == ST_LOOKUP) && any_hit;
  assign mem_req    = (state == ST_REFILL);
  assign fill       = mem_req && mem_valid;   // line arrives this cycle
  assign store      = lookup_hit && we;

  // a set that is not yet full still has an invalid way at fill_cnt
  assign victim = (fill_cnt[index] < CNT_W'(WAYS)) ? WAY_W'(fill_cnt[index])
                                                   : rr_ptr[index];
  assign way_we = fill  ? (WAYS'(1) << victim) :
                  store ? hit_way              : '0;

  // line aligned during refill, byte address for the write-through
  assign mem_addr  = mem_req ? {addr.f.tag, addr.f.index, {OFFSET_W{1'b0}}} : addr.raw;
  assign mem_wdata = wdata;
  assign mem_size  = size;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (req && !done) begin   // old request is still up in the done cycle
          state_nxt = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        state_nxt = any_hit ? ST_IDLE : ST_REFILL;
      end
      ST_REFILL: begin
        if (mem_valid) begin
          state_nxt = ST_LOOKUP;   // look again, this time it hits
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= ST_IDLE;
      done   <= 1'b0;
      mem_we <= 1'b0;
    end else begin
      state  <= state_nxt;
      done   <= lookup_hit;
      mem_we <= store;   // write-through goes out with done
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SETS; s++) begin
        fill_cnt[s] <= '0;
        rr_ptr[s]   <= '0;
      end
    end else if (fill) begin
      if (fill_cnt[index] < CNT_W'(WAYS)) begin
        fill_cnt[index] <= fill_cnt[index] + 1'b1;
      end else if (rr_ptr[index] == WAY_W'(WAYS - 1)) begin
        rr_ptr[index] <= '0;   // wrap
      end else begin
        rr_ptr[index] <= rr_ptr[index] + 1'b1;
      end
    end
  end

endmodule

/* tb_dcache.sv */
module tb_dcache
  import dcache_pkg::*;
;

  localparam int MUST_HIT  = 0;
  localparam int MUST_MISS = 1;
  localparam int EITHER    = 2;
  localparam int MAX_ACCESSES    = 400;   // about 355 accesses in all tests
  localparam int CYCLES_PER_ACC  = 10;    // refill of 6 plus lookup, done and gap
  localparam int MAX_CYCLES      = MAX_ACCESSES * CYCLES_PER_ACC;

  logic              clk;
  logic              rst_n;
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  size_e             size;
  logic              load_unsigned;
  logic [DATA_W-1:0] wdata;
  logic              done;
  logic [DATA_W-1:0] rdata;
  logic              mem_req;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_valid;
  logic [LINE_W-1:0] mem_line;
  logic              mem_we;
  logic [DATA_W-1:0] mem_wdata;
  size_e             mem_size;

  logic [7:0] mem_bytes [4096];   // backing memory as changed by write-through
  logic [7:0] shadow    [4096];   // expected contents as changed by the stimulus
  int         cycle_count;

  dcache_top #(
    .WAYS(2)
  ) dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .we           (we),
    .addr         (addr),
    .size         (size),
    .load_unsigned(load_unsigned),
    .wdata        (wdata),
    .done         (done),
    .rdata        (rdata),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .mem_valid    (mem_valid),
    .mem_line     (mem_line),
    .mem_we       (mem_we),
    .mem_wdata    (mem_wdata),
    .mem_size     (mem_size)
  );

  always #5 clk = ~clk;

  task automatic stop_run();
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_true(input string name, input bit cond, input string what);
    assert (cond) else begin
      $display("%s: %s", name, what);
      stop_run();
    end
  endtask

  // little-endian field from the shadow memory, then extended
  function automatic logic [63:0] expect_load(input logic [31:0] a, input size_e sz,
                                              input logic uns);
    logic [63:0] v;
    int          n;
    v = '0;
    n = 1 << int'(sz);
    for (int k = 0; k < n; k++) begin
      v[8*k +: 8] = shadow[int'(a[11:0]) + k];
    end
    if (!uns && n < 8 && v[8*n-1]) begin
      v = v | ~((64'd1 << (8 * n)) - 64'd1);
    end
    return v;
  endfunction

  task automatic run_access(input string name, input logic wr, input logic [31:0] a,
                            input size_e sz, input logic uns, input logic [63:0] wd,
                            input int mode);
    int          cycles;
    int          valid_at;
    bit          refilled;
    logic [63:0] exp;
    @(posedge clk);
    #1;
    req = 1'b1;
    we = wr;
    addr = a;
    size = sz;
    load_unsigned = uns;
    wdata = wd;
    exp = expect_load(a, sz, uns);
    cycles = 0;
    valid_at = -1;
    refilled = 0;
    @(negedge clk);   // request visible but not yet seen by the FSM
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (mem_req) begin
        refilled = 1;
        check_value({name, " refill addr"}, 64'({a[31:4], 4'h0}), 64'(mem_addr));
      end
      if (mem_valid) valid_at = cycles;
    end
    if (mode == MUST_HIT) check_true(name, !refilled, "unexpected refill on a hit");
    if (mode == MUST_MISS) check_true(name, refilled, "expected a refill, none seen");
    if (refilled) check_value({name, " done after mem_valid"}, 64'(valid_at + 2), 64'(cycles));
    else check_value({name, " hit latency"}, 64'd2, 64'(cycles));
    check_value({name, " mem_we"}, 64'(wr), 64'(mem_we));
    if (wr) begin
      check_value({name, " mem_addr"}, 64'(a), 64'(mem_addr));
      check_value({name, " mem_size"}, 64'(sz), 64'(mem_size));
      check_value({name, " mem_wdata"}, wd, mem_wdata);
      for (int k = 0; k < (1 << int'(sz)); k++) begin
        shadow[int'(a[11:0]) + k] = wd[8*k +: 8];
      end
    end else begin
      check_value({name, " rdata"}, exp, rdata);
    end
  endtask

  // refill after 1 to 6 cycles and write-through applied at once
  initial begin : memory_model
    int         delay;
    logic [11:0] base;
    mem_valid = 1'b0;
    mem_line = '0;
    forever begin
      @(negedge clk);
      if (mem_we) begin
        for (int k = 0; k < (1 << int'(mem_size)); k++) begin
          mem_bytes[int'(mem_addr[11:0]) + k] = mem_wdata[8*k +: 8];
        end
      end
      if (mem_req) begin
        base = mem_addr[11:0];
        delay = int'($urandom_range(1, 6));
        repeat (delay) @(posedge clk);
        #1;
        for (int k = 0; k < 16; k++) begin
          mem_line[8*k +: 8] = mem_bytes[int'(base) + k];
        end
        mem_valid = 1'b1;
        @(posedge clk);
        #1;
        mem_valid = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      stop_run();
    end
  end

  initial begin
    logic [1:0]  rs;
    logic [3:0]  roff;
    logic [31:0] ra;
    void'($urandom(61));
    clk = 1'b0;
    rst_n = 1'b0;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    size = SIZE_BYTE;
    load_unsigned = 1'b0;
    wdata = '0;
    cycle_count = 0;
    for (int i = 0; i < 4096; i++) begin
      mem_bytes[i] = 8'($urandom);
      shadow[i] = mem_bytes[i];
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_true("reset", !done && !mem_req && !mem_we, "outputs not low after reset");

    // first load refills, then hits of every size and sign
    run_access("first_load", 0, 32'h100, SIZE_WORD, 0, '0, MUST_MISS);
    run_access("repeat_byte", 0, 32'h10f, SIZE_BYTE, 0, '0, MUST_HIT);
    run_access("repeat_byte_u", 0, 32'h10f, SIZE_BYTE, 1, '0, MUST_HIT);
    run_access("repeat_half", 0, 32'h106, SIZE_HALF, 0, '0, MUST_HIT);
    run_access("repeat_word_u", 0, 32'h10c, SIZE_WORD, 1, '0, MUST_HIT);
    run_access("repeat_double", 0, 32'h108, SIZE_DOUBLE, 0, '0, MUST_HIT);

    // second tag in the same set where both stay resident
    run_access("second_tag", 0, 32'h508, SIZE_DOUBLE, 0, '0, MUST_MISS);
    run_access("resident_a", 0, 32'h100, SIZE_DOUBLE, 0, '0, MUST_HIT);
    run_access("resident_b", 0, 32'h504, SIZE_WORD, 0, '0, MUST_HIT);

    // stores of every size at every aligned offset
    run_access("line_warm", 0, 32'h200, SIZE_DOUBLE, 0, '0, MUST_MISS);
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 16; off += (1 << s)) begin
        run_access($sformatf("store_s%0d_o%0d", s, off), 1, 32'h200 + 32'(off),
                   size_e'(s[1:0]), 0, {$urandom, $urandom}, MUST_HIT);
        run_access($sformatf("merge_s%0d_o%0d", s, off), 0, 32'h200 + 32'(off & 8),
                   SIZE_DOUBLE, 0, '0, MUST_HIT);
      end
    end
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 16; off += (1 << s)) begin
        run_access($sformatf("sweep_s%0d_o%0d", s, off), 0, 32'h200 + 32'(off),
                   size_e'(s[1:0]), off[1] ^ s[0], '0, MUST_HIT);
      end
    end

    // store allocate, then a third tag in a full set
    run_access("store_alloc", 1, 32'h304, SIZE_WORD, 0, {$urandom, $urandom}, MUST_MISS);
    run_access("store_alloc_rd", 0, 32'h300, SIZE_DOUBLE, 0, '0, MUST_HIT);
    run_access("third_tag", 0, 32'h900, SIZE_DOUBLE, 0, '0, MUST_MISS);
    run_access("after_evict_a", 0, 32'h100, SIZE_DOUBLE, 0, '0, EITHER);
    run_access("after_evict_b", 0, 32'h508, SIZE_DOUBLE, 0, '0, EITHER);
    run_access("after_evict_c", 0, 32'h90c, SIZE_WORD, 1, '0, EITHER);

    // random mix over four tags in two sets
    for (int i = 0; i < 250; i++) begin
      rs = 2'($urandom_range(0, 3));
      roff = 4'($urandom_range(0, 15)) & ~4'((1 << int'(rs)) - 1);
      ra = {20'h0, 2'($urandom_range(0, 3)), 5'h08, 1'($urandom_range(0, 1)), roff};
      run_access($sformatf("random_%0d", i), 1'($urandom_range(0, 1)), ra, size_e'(rs),
                 1'($urandom_range(0, 1)), {$urandom, $urandom}, EITHER);
    end

    @(posedge clk);
    #1;
    req = 1'b0;
    repeat (2) @(posedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule

/* way_select.sv */
module way_select
  import dcache_pkg::*;
#(
  parameter int WAYS = 2
) (
  input  logic                        clk,
  input  logic [WAYS-1:0]             hit,
  input  logic [WAYS-1:0][LINE_W-1:0] line,
  input  logic [OFFSET_W-1:0]         offset,
  input  size_e                       size,
  input  logic                        load_unsigned,
  output logic                        any_hit,
  output logic [WAYS-1:0]             hit_way,
  output logic [DATA_W-1:0]           rdata
);

  logic [LINE_W-1:0] hit_line;
  logic [LINE_W-1:0] shifted;
  logic [DATA_W-1:0] field;

  assign any_hit = |hit;
  assign hit_way = hit;   // one-hot, at most one way matches

  always_comb begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_line = hit_line | (line[w] & {LINE_W{hit[w]}});
    end
  end

  assign shifted = hit_line >> {offset, 3'b000};   // field now at bit 0

  always_comb begin
    case (size)
      SIZE_BYTE: begin
        field = load_unsigned ? DATA_W'(shifted[7:0])
                              : {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
      end
      SIZE_HALF: begin
        field = load_unsigned ? DATA_W'(shifted[15:0])
                              : {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
      end
      SIZE_WORD: begin
        field = load_unsigned ? DATA_W'(shifted[31:0])
                              : {{(DATA_W-32){shifted[31]}}, shifted[31:0]};
      end
      default: begin
        field = shifted[DATA_W-1:0];   // double, no extension
      end
    endcase
  end

  // captured in the hit cycle, held while done is up
  always_ff @(posedge clk) begin
    if (any_hit) begin
      rdata <= field;
    end
  end

endmodule
